// ==== uart_consts.svh ====
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

////////////////////
// Transmit FIFO
////////////////////

`define UART_FIFO_DEPTH 16
`define UART_FIFO_AW    4

////////////////////
// Bit period divider
////////////////////

// Clocks per serial bit, written directly by the host
`define UART_DIV_W      16
`define UART_DIV_RESET  16

////////////////////
// Register map
////////////////////

`define UART_ADDR_CTRL   32'h0000_0000
`define UART_ADDR_DIV    32'h0000_0004
`define UART_ADDR_TXDATA 32'h0000_0008
`define UART_ADDR_STATUS 32'h0000_000C

`endif

// ==== uart_pkg.sv ====
package uart_pkg;

    // Serializer frame states
    typedef enum logic [2:0] {
        TX_IDLE   = 3'd0,
        TX_START  = 3'd1,
        TX_DATA   = 3'd2,
        TX_PARITY = 3'd3,
        TX_STOP   = 3'd4
    } tx_state_t;

    // Register select, taken from address bits [3:2]
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_DIV    = 2'd1,
        REG_TXDATA = 2'd2,
        REG_STATUS = 2'd3
    } reg_sel_t;

endpackage

// ==== uart_if.sv ====
`timescale 1ns/1ps

`include "uart_consts.svh"

// Configuration out to the serializer, busy back to the registers
interface uart_cfg_if;
    logic                   tx_en;
    logic                   parity_en;
    logic                   parity_odd;
    logic [`UART_DIV_W-1:0] baud_div;
    logic                   busy;

    modport regs (output tx_en, parity_en, parity_odd, baud_div, input busy);
    modport ser  (input tx_en, parity_en, parity_odd, baud_div, output busy);
endinterface

// Write side of the transmit FIFO
interface uart_fifo_wr_if;
    logic                    push;
    logic [7:0]              push_data;
    logic                    full;
    logic [`UART_FIFO_AW:0]  level;

    modport regs (output push, push_data, input full, level);
    modport fifo (input push, push_data, output full, level);
endinterface

// ==== uart_regs.sv ====
`timescale 1ns/1ps

`include "uart_consts.svh"

module uart_regs (
    input  logic         clk,
    input  logic         nrst,
    input  logic [31:0]  s_awaddr,
    input  logic         s_awvalid,
    output logic         s_awready,
    input  logic [31:0]  s_wdata,
    input  logic [3:0]   s_wstrb,
    input  logic         s_wvalid,
    output logic         s_wready,
    output logic [1:0]   s_bresp,
    output logic         s_bvalid,
    input  logic         s_bready,
    input  logic [31:0]  s_araddr,
    input  logic         s_arvalid,
    output logic         s_arready,
    output logic [31:0]  s_rdata,
    output logic [1:0]   s_rresp,
    output logic         s_rvalid,
    input  logic         s_rready,
    uart_cfg_if.regs     cfg,
    uart_fifo_wr_if.regs fwr,
    input  logic         fifo_empty
);

    logic                   aw_held;
    logic                   w_held;
    logic [31:0]            aw_addr;
    logic [31:0]            w_data;
    logic                   do_write;
    uart_pkg::reg_sel_t     wr_sel;
    uart_pkg::reg_sel_t     rd_sel;
    logic [31:0]            rd_word;
    logic                   tx_en;
    logic                   parity_en;
    logic                   parity_odd;
    logic [`UART_DIV_W-1:0] baud_div;
    logic                   overflow;

    // Only the four aligned offsets are mapped
    function automatic logic addr_hit(input logic [31:0] addr);
        return (addr == `UART_ADDR_CTRL) || (addr == `UART_ADDR_DIV) ||
               (addr == `UART_ADDR_TXDATA) || (addr == `UART_ADDR_STATUS);
    endfunction

    ////////////////////
    // Write channel
    ////////////////////

    assign s_awready = !aw_held && !s_bvalid;
    assign s_wready  = !w_held && !s_bvalid;
    assign s_bresp   = 2'b00;
    assign do_write  = aw_held && w_held && !s_bvalid;
    assign wr_sel    = uart_pkg::reg_sel_t'(aw_addr[3:2]);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            aw_held  <= 1'b0;
            w_held   <= 1'b0;
            s_bvalid <= 1'b0;
        end else begin
            if (s_awvalid && s_awready)
                aw_held <= 1'b1;
            if (s_wvalid && s_wready)
                w_held <= 1'b1;
            if (do_write) begin
                aw_held  <= 1'b0;
                w_held   <= 1'b0;
                s_bvalid <= 1'b1;
            end else if (s_bready) begin
                s_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_awvalid && s_awready)
            aw_addr <= s_awaddr;
        if (s_wvalid && s_wready)
            w_data <= s_wdata;
    end

    // Byte goes to the FIFO in the same cycle the register write happens
    assign fwr.push = do_write && addr_hit(aw_addr) && (wr_sel == uart_pkg::REG_TXDATA) &&
                      !fwr.full;
    assign fwr.push_data = w_data[7:0];

    always_ff @(posedge clk) begin
        if (!nrst) begin
            tx_en      <= 1'b0;
            parity_en  <= 1'b0;
            parity_odd <= 1'b0;
            baud_div   <= `UART_DIV_W'(`UART_DIV_RESET);
            overflow   <= 1'b0;
        end else if (do_write && addr_hit(aw_addr)) begin
            case (wr_sel)
                uart_pkg::REG_CTRL: begin
                    tx_en      <= w_data[0];
                    parity_en  <= w_data[1];
                    parity_odd <= w_data[2];
                end
                uart_pkg::REG_DIV:
                    // Clamp so every bit lasts at least two clocks
                    baud_div <= (w_data[`UART_DIV_W-1:0] < `UART_DIV_W'(2)) ?
                                `UART_DIV_W'(2) : w_data[`UART_DIV_W-1:0];
                uart_pkg::REG_TXDATA:
                    if (fwr.full)
                        overflow <= 1'b1;
                default:
                    overflow <= 1'b0;
            endcase
        end
    end

    assign cfg.tx_en      = tx_en;
    assign cfg.parity_en  = parity_en;
    assign cfg.parity_odd = parity_odd;
    assign cfg.baud_div   = baud_div;

    ////////////////////
    // Read channel
    ////////////////////

    assign s_arready = !s_rvalid;
    assign s_rresp   = 2'b00;
    assign rd_sel    = uart_pkg::reg_sel_t'(s_araddr[3:2]);

    always_comb begin
        case (rd_sel)
            uart_pkg::REG_CTRL:   rd_word = {29'd0, parity_odd, parity_en, tx_en};
            uart_pkg::REG_DIV:    rd_word = {{(32-`UART_DIV_W){1'b0}}, baud_div};
            uart_pkg::REG_STATUS: rd_word = {{(27-`UART_FIFO_AW){1'b0}}, fwr.level, overflow,
                                             cfg.busy, fwr.full, fifo_empty};
            default:              rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst)
            s_rvalid <= 1'b0;
        else if (s_arvalid && s_arready)
            s_rvalid <= 1'b1;
        else if (s_rready)
            s_rvalid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (s_arvalid && s_arready)
            s_rdata <= addr_hit(s_araddr) ? rd_word : 32'd0;
    end

    a_bvalid_after_pair: assert property (@(posedge clk) disable iff (!nrst)
        $rose(s_bvalid) |-> $past(aw_held && w_held));

    // Checked against the FIFO level rather than its full flag
    a_no_push_full: assert property (@(posedge clk) disable iff (!nrst)
        fwr.push |-> (fwr.level < (`UART_FIFO_AW+1)'(`UART_FIFO_DEPTH)));

endmodule

// ==== uart_tx_fifo.sv ====
`timescale 1ns/1ps

`include "uart_consts.svh"

module uart_tx_fifo (
    input  logic         clk,
    input  logic         nrst,
    uart_fifo_wr_if.fifo wr,
    input  logic         pop,
    output logic [7:0]   pop_data,
    output logic         empty
);

    logic [7:0]              mem [`UART_FIFO_DEPTH];
    logic [`UART_FIFO_AW-1:0] wptr;
    logic [`UART_FIFO_AW-1:0] rptr;
    logic [`UART_FIFO_AW:0]   level;

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (wr.push)
            mem[wptr] <= wr.push_data;
    end

    // Head entry, no read latency
    assign pop_data = mem[rptr];

    ////////////////////
    // Pointers and level
    ////////////////////

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wptr  <= '0;
            rptr  <= '0;
            level <= '0;
        end else begin
            // Pointers wrap naturally at the depth
            if (wr.push)
                wptr <= wptr + 1'b1;
            if (pop)
                rptr <= rptr + 1'b1;
            case ({wr.push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    assign empty    = (level == '0);
    assign wr.full  = (level == (`UART_FIFO_AW+1)'(`UART_FIFO_DEPTH));
    assign wr.level = level;

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!nrst)
        pop |-> !empty);

endmodule

// ==== uart_tx_serializer.sv ====
`timescale 1ns/1ps

`include "uart_consts.svh"

module uart_tx_serializer (
    input  logic       clk,
    input  logic       nrst,
    uart_cfg_if.ser    cfg,
    output logic       pop,
    input  logic [7:0] pop_data,
    input  logic       empty,
    output logic       txd
);

    uart_pkg::tx_state_t    state;
    logic [`UART_DIV_W-1:0] cnt;
    logic [`UART_DIV_W-1:0] div_q;
    logic [2:0]             bit_idx;
    logic [7:0]             shreg;
    logic                   par_bit;
    logic                   par_en_q;
    logic                   bit_end;

    assign bit_end  = (cnt == div_q - `UART_DIV_W'(1));
    assign cfg.busy = (state != uart_pkg::TX_IDLE);

    // Take the next byte from idle or straight out of a stop bit
    assign pop = cfg.tx_en && !empty &&
                 ((state == uart_pkg::TX_IDLE) || ((state == uart_pkg::TX_STOP) && bit_end));

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state   <= uart_pkg::TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    cnt <= '0;
                    if (pop) begin
                        state <= uart_pkg::TX_START;
                        txd   <= 1'b0;
                    end
                end
                uart_pkg::TX_START: begin
                    cnt <= bit_end ? '0 : cnt + 1'b1;
                    if (bit_end) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_idx <= '0;
                        txd     <= shreg[0];
                    end
                end
                uart_pkg::TX_DATA: begin
                    cnt <= bit_end ? '0 : cnt + 1'b1;
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= par_en_q ? uart_pkg::TX_PARITY : uart_pkg::TX_STOP;
                            txd   <= par_en_q ? par_bit : 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= shreg[1];
                        end
                    end
                end
                uart_pkg::TX_PARITY: begin
                    cnt <= bit_end ? '0 : cnt + 1'b1;
                    if (bit_end) begin
                        state <= uart_pkg::TX_STOP;
                        txd   <= 1'b1;
                    end
                end
                uart_pkg::TX_STOP: begin
                    cnt <= bit_end ? '0 : cnt + 1'b1;
                    if (bit_end) begin
                        // Back to back frame when more data waits
                        state <= pop ? uart_pkg::TX_START : uart_pkg::TX_IDLE;
                        txd   <= !pop;
                    end
                end
                default: begin
                    state <= uart_pkg::TX_IDLE;
                    txd   <= 1'b1;
                end
            endcase
        end
    end

    ////////////////////
    // Frame data
    ////////////////////

    // Divider and parity settings are frozen per frame at the pop
    always_ff @(posedge clk) begin
        if (pop) begin
            shreg    <= pop_data;
            par_bit  <= (^pop_data) ^ cfg.parity_odd;
            par_en_q <= cfg.parity_en;
            div_q    <= cfg.baud_div;
        end else if ((state == uart_pkg::TX_DATA) && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!nrst)
        (state == uart_pkg::TX_IDLE) |-> txd);

endmodule

// ==== uart_tx_top.sv ====
`timescale 1ns/1ps

module uart_tx_top (
    input  logic        clk,
    input  logic        nrst,
    input  logic [31:0] s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic [3:0]  s_wstrb,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [31:0] s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready,
    output logic        txd
);

    logic       pop;
    logic [7:0] pop_data;
    logic       empty;

    uart_cfg_if     cfg_bus ();
    uart_fifo_wr_if fwr_bus ();

    // Host side register block
    uart_regs u_regs (
        .clk, .nrst,
        .s_awaddr, .s_awvalid, .s_awready,
        .s_wdata, .s_wstrb, .s_wvalid, .s_wready,
        .s_bresp, .s_bvalid, .s_bready,
        .s_araddr, .s_arvalid, .s_arready,
        .s_rdata, .s_rresp, .s_rvalid, .s_rready,
        .cfg        (cfg_bus.regs),
        .fwr        (fwr_bus.regs),
        .fifo_empty (empty)
    );

    uart_tx_fifo u_fifo (
        .clk, .nrst,
        .wr       (fwr_bus.fifo),
        .pop      (pop),
        .pop_data (pop_data),
        .empty    (empty)
    );

    // Line side
    uart_tx_serializer u_ser (
        .clk, .nrst,
        .cfg      (cfg_bus.ser),
        .pop      (pop),
        .pop_data (pop_data),
        .empty    (empty),
        .txd      (txd)
    );

endmodule

// ==== tb_uart_tx.sv ====
`timescale 1ns/1ps

`include "uart_consts.svh"

module tb_uart_tx;

    localparam int WAIT_LIMIT  = 200;
    localparam int START_LIMIT = 5000;
    localparam int DRAIN_LIMIT = 20000;

    logic        clk;
    logic        nrst;
    logic [31:0] s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic [3:0]  s_wstrb;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [31:0] s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;
    logic        txd;

    int    errors;
    int    checks;
    int    cycle;
    int    exp_count;
    int    rx_count;
    int    compared;
    int    last_start;
    int    cur_div;
    logic  cur_par_en;
    string phase;

    // Bytes queued for the line, with the settings in force at their pop
    logic [7:0]  exp_byte [$];
    logic        exp_par_en [$];
    logic        exp_par_odd [$];
    int          exp_div [$];
    logic        exp_b2b [$];
    // Frames captured on txd
    logic [10:0] rx_frame [$];
    int          rx_rise [$];
    int          rx_gap [$];

    uart_tx_top DUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////
    // Reference model
    ////////////////////

    // Line bits in send order: start, data LSB first, optional parity, stop
    function automatic logic [10:0] expected_frame(input logic [7:0] b, input logic pe,
                                                   input logic po);
        logic [10:0] f;
        int          ones;
        f = '0;
        f[8:1] = b;
        ones = $countones(b);
        if (pe) begin
            // Even sense makes the ones count of data and parity even
            if (po)
                f[9] = (ones % 2 == 0);
            else
                f[9] = (ones % 2 == 1);
            f[10] = 1'b1;
        end else begin
            f[9] = 1'b1;
        end
        return f;
    endfunction

    // Bit index where the last low to high transition on the line starts
    function automatic int last_rise_bit(input logic [10:0] frame, input int nbits);
        int idx;
        idx = 0;
        for (int i = 1; i < nbits; i++)
            if (frame[i] && !frame[i-1])
                idx = i;
        return idx;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("STATUS: FAIL");
        $finish;
    endtask

    ////////////////////
    // AXI4-Lite master
    ////////////////////

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
        int         waited;
        logic       aw_hit;
        logic       w_hit;
        logic       done;
        logic [1:0] resp;
        @(posedge clk);
        #1;
        s_awaddr  = addr;
        s_awvalid = 1'b1;
        s_wdata   = data;
        s_wstrb   = 4'hF;
        s_wvalid  = 1'b1;
        waited    = 0;
        while (s_awvalid || s_wvalid) begin
            @(negedge clk);
            aw_hit = s_awvalid && s_awready;
            w_hit  = s_wvalid && s_wready;
            @(posedge clk);
            #1;
            if (aw_hit)
                s_awvalid = 1'b0;
            if (w_hit)
                s_wvalid = 1'b0;
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("write address or data never accepted");
        end
        s_bready = 1'b1;
        done     = 1'b0;
        waited   = 0;
        while (!done) begin
            @(negedge clk);
            done = s_bvalid;
            resp = s_bresp;
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("no write response");
        end
        s_bready = 1'b0;
        check_value("write response", 32'd0, resp);
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data);
        int         waited;
        logic       done;
        logic [1:0] resp;
        @(posedge clk);
        #1;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        waited    = 0;
        while (s_arvalid) begin
            @(negedge clk);
            done = s_arready;
            @(posedge clk);
            #1;
            if (done)
                s_arvalid = 1'b0;
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("read address never accepted");
        end
        s_rready = 1'b1;
        done     = 1'b0;
        waited   = 0;
        while (!done) begin
            @(negedge clk);
            done = s_rvalid;
            data = s_rdata;
            resp = s_rresp;
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("no read data");
        end
        s_rready = 1'b0;
        check_value("read response", 32'd0, resp);
    endtask

    ////////////////////
    // Stimulus helpers
    ////////////////////

    task automatic queue_byte(input logic [7:0] b, input logic pe, input logic po,
                              input logic b2b);
        exp_byte.push_back(b);
        exp_par_en.push_back(pe);
        exp_par_odd.push_back(po);
        exp_div.push_back(cur_div);
        exp_b2b.push_back(b2b);
        exp_count++;
    endtask

    task automatic wait_for_room();
        logic [31:0] st;
        int          tries;
        tries = 0;
        axi_read(`UART_ADDR_STATUS, st);
        while (st[1]) begin
            tries++;
            if (tries > WAIT_LIMIT)
                abort_run("FIFO stayed full");
            axi_read(`UART_ADDR_STATUS, st);
        end
    endtask

    task automatic send_byte(input logic [7:0] b, input logic pe, input logic po);
        wait_for_room();
        queue_byte(b, pe, po, 1'b0);
        axi_write(`UART_ADDR_TXDATA, {24'd0, b});
    endtask

    // All queued frames checked and the serializer back in idle
    task automatic drain_line();
        logic [31:0] st;
        int          waited;
        waited = 0;
        while (compared < exp_count) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_LIMIT)
                abort_run("queued frames never appeared on txd");
        end
        waited = 0;
        axi_read(`UART_ADDR_STATUS, st);
        while (st[2] || !st[0]) begin
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("serializer never went idle");
            axi_read(`UART_ADDR_STATUS, st);
        end
    endtask

    ////////////////////
    // Line monitor
    ////////////////////

    task automatic capture_frame();
        int          waited;
        int          n;
        int          nbits;
        int          div;
        int          last_rise;
        int          start_cycle;
        logic        prev;
        logic [10:0] bits;
        div    = cur_div;
        nbits  = cur_par_en ? 11 : 10;
        waited = 0;
        prev   = txd;
        while (!(prev === 1'b1 && txd === 1'b0)) begin
            prev = txd;
            @(negedge clk);
            waited++;
            if (waited > START_LIMIT)
                abort_run("no start bit on txd");
        end
        start_cycle = cycle;
        bits        = '0;
        last_rise   = 0;
        prev        = 1'b0;
        // Count half-cycle-offset samples from the start edge, pick bit centres
        for (n = 1; n <= (nbits - 1) * div + div / 2; n++) begin
            @(negedge clk);
            if (!prev && txd)
                last_rise = n;
            prev = txd;
            if (n % div == div / 2)
                bits[n / div] = txd;
        end
        rx_frame.push_back(bits);
        rx_rise.push_back(last_rise);
        rx_gap.push_back(start_cycle - last_start);
        last_start = start_cycle;
        rx_count++;
    endtask

    initial begin : line_monitor
        forever begin
            @(negedge clk);
            if (nrst && (rx_count < exp_count))
                capture_frame();
        end
    end

    task automatic compare_next_frame();
        logic [10:0] got;
        logic [10:0] want;
        logic [7:0]  b;
        logic        pe;
        logic        po;
        logic        b2b;
        int          rise;
        int          gap;
        int          div;
        int          nbits;
        int          edge_at;
        got  = rx_frame.pop_front();
        rise = rx_rise.pop_front();
        gap  = rx_gap.pop_front();
        checks++;
        assert (exp_byte.size() > 0) else begin
            errors++;
            $display("A frame appeared on txd with no byte queued for it");
        end
        if (exp_byte.size() > 0) begin
            b       = exp_byte.pop_front();
            pe      = exp_par_en.pop_front();
            po      = exp_par_odd.pop_front();
            div     = exp_div.pop_front();
            b2b     = exp_b2b.pop_front();
            want    = expected_frame(b, pe, po);
            nbits   = pe ? 11 : 10;
            edge_at = last_rise_bit(want, nbits) * div;
            check_value($sformatf("%s frame %h", phase, b), want, got);
            checks++;
            assert ((rise >= edge_at - 1) && (rise <= edge_at + 1)) else begin
                errors++;
                $display("FAIL %s edge timing %h: expected %0d, actual %0d",
                         phase, b, edge_at, rise);
            end
            if (b2b)
                check_value($sformatf("%s frame gap %h", phase, b), nbits * div, gap);
        end
        compared++;
    endtask

    initial begin : frame_checker
        forever begin
            @(posedge clk);
            while (rx_frame.size() > 0)
                compare_next_frame();
        end
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin : main_seq
        logic [31:0] rd;
        logic [7:0]  stored [16];
        logic        line_low;
        clk = 1'b0;
        nrst = 1'b0;
        s_awaddr = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        s_araddr = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        errors = 0;
        checks = 0;
        cycle = 0;
        exp_count = 0;
        rx_count = 0;
        compared = 0;
        last_start = 0;
        cur_div = `UART_DIV_RESET;
        cur_par_en = 1'b0;
        void'($urandom(32'h396b3515));
        repeat (10) @(posedge clk);
        #1;
        nrst = 1'b1;

        // Reset values
        phase = "reset";
        check_value("reset txd", 32'd1, txd);
        axi_read(`UART_ADDR_STATUS, rd);
        check_value("reset STATUS", 32'h0000_0001, rd);
        axi_read(`UART_ADDR_CTRL, rd);
        check_value("reset CTRL", 32'd0, rd);
        axi_read(`UART_ADDR_DIV, rd);
        check_value("reset DIV", 32'd16, rd);
        axi_write(`UART_ADDR_DIV, 32'd1);
        axi_read(`UART_ADDR_DIV, rd);
        check_value("DIV clamp", 32'd2, rd);

        // Single frames without parity
        phase = "single";
        cur_div = 8;
        axi_write(`UART_ADDR_DIV, 32'd8);
        axi_write(`UART_ADDR_CTRL, 32'h1);
        send_byte(8'h55, 1'b0, 1'b0);
        drain_line();
        send_byte(8'h00, 1'b0, 1'b0);
        drain_line();
        send_byte(8'hFF, 1'b0, 1'b0);
        drain_line();
        send_byte(8'hA3, 1'b0, 1'b0);
        drain_line();

        // Even then odd parity
        phase = "parity even";
        cur_par_en = 1'b1;
        axi_write(`UART_ADDR_CTRL, 32'h3);
        for (int i = 0; i < 20; i++)
            send_byte(8'($urandom()), 1'b1, 1'b0);
        drain_line();
        phase = "parity odd";
        axi_write(`UART_ADDR_CTRL, 32'h7);
        for (int i = 0; i < 20; i++)
            send_byte(8'($urandom()), 1'b1, 1'b1);
        drain_line();

        // Fill with the transmitter off, overflow, then release
        phase = "fill";
        cur_par_en = 1'b0;
        axi_write(`UART_ADDR_CTRL, 32'h0);
        for (int i = 0; i < 16; i++) begin
            stored[i] = 8'($urandom());
            axi_write(`UART_ADDR_TXDATA, {24'd0, stored[i]});
        end
        axi_read(`UART_ADDR_STATUS, rd);
        check_value("fill STATUS full", 32'h0000_0102, rd);
        line_low = 1'b0;
        repeat (40) begin
            @(negedge clk);
            if (txd !== 1'b1)
                line_low = 1'b1;
        end
        check_value("fill txd idle", 32'd0, line_low);
        axi_write(`UART_ADDR_TXDATA, 32'h0000_005A);
        axi_read(`UART_ADDR_STATUS, rd);
        check_value("fill STATUS overflow", 32'h0000_010A, rd);
        axi_write(`UART_ADDR_STATUS, 32'd0);
        axi_read(`UART_ADDR_STATUS, rd);
        check_value("fill STATUS cleared", 32'h0000_0102, rd);
        for (int i = 0; i < 16; i++)
            queue_byte(stored[i], 1'b0, 1'b0, i > 0);
        axi_write(`UART_ADDR_CTRL, 32'h1);
        drain_line();
        axi_read(`UART_ADDR_STATUS, rd);
        check_value("fill STATUS drained", 32'h0000_0001, rd);

        // Divider change between bursts
        phase = "div 8";
        for (int i = 0; i < 6; i++)
            send_byte(8'($urandom()), 1'b0, 1'b0);
        drain_line();
        phase = "div 12";
        cur_div = 12;
        axi_write(`UART_ADDR_DIV, 32'd12);
        for (int i = 0; i < 6; i++)
            send_byte(8'($urandom()), 1'b0, 1'b0);
        drain_line();
        check_value("final txd", 32'd1, txd);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
uart_pkg.sv
uart_if.sv
uart_regs.sv
uart_tx_fifo.sv
uart_tx_serializer.sv
uart_tx_top.sv
tb_uart_tx.sv
